/* dv/tb_mem_island.sv */
`timescale 1ns/1ps

module tb_mem_island import mem_island_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 64;

    logic                                       clk;
    logic                                       arst_n;
    logic [NUM_NARROW_PORTS-1:0]                nreq_valid;
    logic [NUM_NARROW_PORTS-1:0]                nreq_ready;
    logic [NUM_NARROW_PORTS-1:0][ADDR_W-1:0]    nreq_addr;
    logic [NUM_NARROW_PORTS-1:0]                nreq_we;
    logic [NUM_NARROW_PORTS-1:0][NARROW_DW-1:0] nreq_wdata;
    logic [NUM_NARROW_PORTS-1:0][NARROW_BE-1:0] nreq_be;
    logic [NUM_NARROW_PORTS-1:0]                nrsp_valid;
    logic [NUM_NARROW_PORTS-1:0][NARROW_DW-1:0] nrsp_rdata;
    logic                                       wreq_valid;
    logic                                       wreq_ready;
    logic [ADDR_W-1:0]                          wreq_addr;
    logic                                       wreq_we;
    logic [WIDE_DW-1:0]                         wreq_wdata;
    logic [WIDE_BE-1:0]                         wreq_be;
    logic                                       wrsp_valid;
    logic [WIDE_DW-1:0]                         wrsp_rdata;

    // Reference model, one byte per byte address
    logic [7:0]                                 mem_model [1 << ADDR_W];
    logic [NUM_NARROW_PORTS-1:0]                exp_nvalid;
    logic [NUM_NARROW_PORTS-1:0][NARROW_DW-1:0] exp_nrdata;
    logic                                       exp_wvalid;
    logic [WIDE_DW-1:0]                         exp_wrdata;
    integer                                     seed;
    bit                                         narrow_done;

    mem_island_top mem_island_top_inst (
        .clk_i(clk), .arst_n_i(arst_n),
        .nreq_valid_i(nreq_valid), .nreq_ready_o(nreq_ready), .nreq_addr_i(nreq_addr),
        .nreq_we_i(nreq_we), .nreq_wdata_i(nreq_wdata), .nreq_be_i(nreq_be),
        .nrsp_valid_o(nrsp_valid), .nrsp_rdata_o(nrsp_rdata),
        .wreq_valid_i(wreq_valid), .wreq_ready_o(wreq_ready), .wreq_addr_i(wreq_addr),
        .wreq_we_i(wreq_we), .wreq_wdata_i(wreq_wdata), .wreq_be_i(wreq_be),
        .wrsp_valid_o(wrsp_valid), .wrsp_rdata_o(wrsp_rdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ----------------------------------------
    // Failure reporting and compares
    // ----------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_narrow_rdata(input string name, input logic [NARROW_DW-1:0] got,
                                      input logic [NARROW_DW-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_wide_rdata(input string name, input logic [WIDE_DW-1:0] got,
                                    input logic [WIDE_DW-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // ----------------------------------------
    // Model access
    // ----------------------------------------
    // Byte j of a word sits at offset j, so wide byte j is part j/4, offset j%4
    function automatic logic [NARROW_DW-1:0] model_read_word(input mem_addr_u a);
        logic [NARROW_DW-1:0] d;
        mem_addr_u            ba;
        ba = a;
        for (int j = 0; j < NARROW_BE; j++) begin
            ba.narrow.offset = OFFSET_W'(j);
            d[j*8 +: 8] = mem_model[ba];
        end
        return d;
    endfunction

    function automatic void model_write_word(input mem_addr_u a, input logic [NARROW_DW-1:0] d,
                                             input logic [NARROW_BE-1:0] be);
        mem_addr_u ba;
        ba = a;
        for (int j = 0; j < NARROW_BE; j++) begin
            ba.narrow.offset = OFFSET_W'(j);
            if (be[j]) begin
                mem_model[ba] = d[j*8 +: 8];
            end
        end
    endfunction

    function automatic logic [WIDE_DW-1:0] model_read_wide(input mem_addr_u a);
        logic [WIDE_DW-1:0] d;
        mem_addr_u          ba;
        ba = a;
        for (int k = 0; k < BANKS_PER_GROUP; k++) begin
            ba.wide.part = PART_SEL_W'(k);
            d[k*NARROW_DW +: NARROW_DW] = model_read_word(ba);
        end
        return d;
    endfunction

    function automatic void model_write_wide(input mem_addr_u a, input logic [WIDE_DW-1:0] d,
                                             input logic [WIDE_BE-1:0] be);
        mem_addr_u ba;
        ba = a;
        for (int k = 0; k < BANKS_PER_GROUP; k++) begin
            ba.wide.part = PART_SEL_W'(k);
            model_write_word(ba, d[k*NARROW_DW +: NARROW_DW], be[k*NARROW_BE +: NARROW_BE]);
        end
    endfunction

    // ----------------------------------------
    // Monitor, sampled mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin : monitor
        mem_addr_u                   na [NUM_NARROW_PORTS];
        mem_addr_u                   wa;
        logic [NUM_NARROW_PORTS-1:0] acc;
        logic                        wacc;
        // Responses owed by last cycle's acceptances
        for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
            if (nrsp_valid[p] !== exp_nvalid[p]) begin
                report_failure($sformatf("error nrsp_valid_o[%0d]: got %h, expected %h",
                                         p, nrsp_valid[p], exp_nvalid[p]));
            end
            if (exp_nvalid[p]) begin
                check_narrow_rdata($sformatf("nrsp_rdata_o[%0d]", p), nrsp_rdata[p],
                                   exp_nrdata[p]);
            end
        end
        if (wrsp_valid !== exp_wvalid) begin
            report_failure($sformatf("error wrsp_valid_o: got %h, expected %h",
                                     wrsp_valid, exp_wvalid));
        end
        if (exp_wvalid) begin
            check_wide_rdata("wrsp_rdata_o", wrsp_rdata, exp_wrdata);
        end
        // New acceptances
        for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
            na[p] = nreq_addr[p];
            acc[p] = nreq_valid[p] && (nreq_ready[p] === 1'b1);
        end
        for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
            for (int q = p + 1; q < NUM_NARROW_PORTS; q++) begin
                if (acc[p] && acc[q] && na[p].narrow.bank == na[q].narrow.bank) begin
                    report_failure($sformatf("bank %0d accepted two narrow ports in one cycle",
                                             na[p].narrow.bank));
                end
            end
        end
        for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
            exp_nvalid[p] = acc[p];
            if (acc[p] && nreq_we[p]) begin
                exp_nrdata[p] = '0;
                model_write_word(na[p], nreq_wdata[p], nreq_be[p]);
            end else if (acc[p]) begin
                exp_nrdata[p] = model_read_word(na[p]);
            end
        end
        wa = wreq_addr;
        wacc = wreq_valid && (wreq_ready === 1'b1);
        exp_wvalid = wacc;
        if (wacc && wreq_we) begin
            exp_wrdata = '0;
            model_write_wide(wa, wreq_wdata, wreq_be);
        end else if (wacc) begin
            exp_wrdata = model_read_wide(wa);
        end
    end

    // ----------------------------------------
    // Request drivers
    // ----------------------------------------
    // Called 1 ns after a rising edge, return 1 ns after the accepting edge
    task automatic narrow_access(input int p, input mem_addr_u addr, input logic we,
                                 input logic [NARROW_DW-1:0] wdata,
                                 input logic [NARROW_BE-1:0] be, output int waited);
        bit accepted;
        waited = 0;
        accepted = 1'b0;
        nreq_valid[p] = 1'b1;
        nreq_addr[p]  = addr;
        nreq_we[p]    = we;
        nreq_wdata[p] = wdata;
        nreq_be[p]    = be;
        while (!accepted) begin
            @(negedge clk);
            accepted = nreq_ready[p];
            @(posedge clk);
            #1;
            if (!accepted) begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    report_failure($sformatf("narrow port %0d was not accepted in %0d cycles",
                                             p, TIMEOUT_CYCLES));
                end
            end
        end
        nreq_valid[p] = 1'b0;
    endtask

    task automatic wide_access(input mem_addr_u addr, input logic we,
                               input logic [WIDE_DW-1:0] wdata, input logic [WIDE_BE-1:0] be);
        bit accepted;
        int waited;
        waited = 0;
        accepted = 1'b0;
        wreq_valid = 1'b1;
        wreq_addr  = addr;
        wreq_we    = we;
        wreq_wdata = wdata;
        wreq_be    = be;
        while (!accepted) begin
            @(negedge clk);
            accepted = wreq_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!accepted && waited > TIMEOUT_CYCLES) begin
                report_failure("wide port request was never accepted");
            end
        end
        wreq_valid = 1'b0;
    endtask

    function automatic mem_addr_u rand_addr(input logic [GROUP_SEL_W-1:0] group);
        mem_addr_u a;
        a = '0;
        a.wide.in_bank = IN_BANK_AW'($random(seed));
        a.wide.group   = group;
        a.wide.part    = PART_SEL_W'($random(seed));
        return a;
    endfunction

    function automatic logic [WIDE_DW-1:0] rand_wide_data();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int        waited;
        int        p;
        mem_addr_u a;
        mem_addr_u b;
        seed = 32'h58bc_eb06;
        arst_n = 1'b0;
        nreq_valid = '0;
        nreq_addr = '0;
        nreq_we = '0;
        nreq_wdata = '0;
        nreq_be = '0;
        wreq_valid = 1'b0;
        wreq_addr = '0;
        wreq_we = 1'b0;
        wreq_wdata = '0;
        wreq_be = '0;
        exp_nvalid = '0;
        exp_nrdata = '0;
        exp_wvalid = 1'b0;
        exp_wrdata = '0;
        narrow_done = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (3) @(posedge clk);
        #1;

        // Fill every wide word so that no read returns unknown data
        for (int i = 0; i < NUM_GROUPS * WORDS_PER_BANK; i++) begin
            a = '0;
            a.wide.in_bank = IN_BANK_AW'(i);
            a.wide.group = GROUP_SEL_W'(i / WORDS_PER_BANK);
            wide_access(a, 1'b1, rand_wide_data(), '1);
        end

        // Narrow writes with random strobes, then narrow reads
        for (int i = 0; i < 120; i++) begin
            a = rand_addr(GROUP_SEL_W'($random(seed)));
            p = int'(PORT_SEL_W'($random(seed)));
            narrow_access(p, a, 1'b1, $random(seed), NARROW_BE'($random(seed)), waited);
        end
        for (int i = 0; i < 120; i++) begin
            a = rand_addr(GROUP_SEL_W'($random(seed)));
            p = int'(PORT_SEL_W'($random(seed)));
            narrow_access(p, a, 1'b0, '0, '0, waited);
        end

        // Byte order between the wide and narrow views
        for (int i = 0; i < 30; i++) begin
            a = rand_addr(GROUP_SEL_W'($random(seed)));
            a.wide.part = '0;
            wide_access(a, 1'b1, rand_wide_data(), WIDE_BE'({$random(seed), $random(seed)}));
            for (int k = 0; k < BANKS_PER_GROUP; k++) begin
                b = a;
                b.wide.part = PART_SEL_W'(k);
                narrow_access(k % NUM_NARROW_PORTS, b, 1'b0, '0, '0, waited);
            end
            b.wide.part = PART_SEL_W'($random(seed));
            narrow_access(0, b, 1'b1, $random(seed), NARROW_BE'($random(seed)), waited);
            wide_access(a, 1'b0, '0, '0);
        end

        // Both narrow ports on one bank
        for (int i = 0; i < 40; i++) begin
            a = rand_addr(GROUP_SEL_W'($random(seed)));
            b = a;
            b.narrow.in_bank = IN_BANK_AW'($random(seed));
            fork
                narrow_access(0, a, 1'($random(seed)), $random(seed), '1, waited);
                narrow_access(1, b, 1'($random(seed)), $random(seed), '1, waited);
            join
        end

        // Continuous wide traffic against narrow requests in the same group
        for (int g = 0; g < NUM_GROUPS; g++) begin
            narrow_done = 1'b0;
            fork
                begin : wide_stream
                    int n;
                    n = 0;
                    while (!narrow_done) begin
                        a = rand_addr(GROUP_SEL_W'(g));
                        wide_access(a, 1'($random(seed)), rand_wide_data(),
                                    WIDE_BE'({$random(seed), $random(seed)}));
                        n++;
                        if (n > 4 * TIMEOUT_CYCLES) begin
                            report_failure("narrow requests did not finish under wide load");
                        end
                    end
                end
                begin : narrow_stream
                    int w;
                    for (int i = 0; i < 30; i++) begin
                        b = rand_addr(GROUP_SEL_W'(g));
                        narrow_access(0, b, 1'($random(seed)), $random(seed),
                                      NARROW_BE'($random(seed)), w);
                        if (w > 1) begin
                            report_failure($sformatf("narrow request waited %0d cycles behind %s",
                                                     w, "the wide port"));
                        end
                    end
                    narrow_done = 1'b1;
                end
            join
        end

        repeat (3) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_island -f vlog.f \
    --Mdir obj_dir -o tb_mem_island_sim

./obj_dir/tb_mem_island_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* source/bank_group_arbiter.sv */
`timescale 1ns/1ps

module bank_group_arbiter import mem_island_pkg::*; (
    input  logic                                        clk_i,
    input  logic                                        arst_n_i,
    // Narrow requests for this group
    input  logic [BANKS_PER_GROUP-1:0]                  bnreq_valid_i,
    input  logic [BANKS_PER_GROUP-1:0][IN_BANK_AW-1:0]  bnreq_addr_i,
    input  logic [BANKS_PER_GROUP-1:0]                  bnreq_we_i,
    input  logic [BANKS_PER_GROUP-1:0][NARROW_DW-1:0]   bnreq_wdata_i,
    input  logic [BANKS_PER_GROUP-1:0][NARROW_BE-1:0]   bnreq_be_i,
    output logic [BANKS_PER_GROUP-1:0]                  bnreq_gnt_o,
    // Wide request
    input  logic                                        gwreq_valid_i,
    input  logic [IN_BANK_AW-1:0]                       wreq_addr_i,
    input  logic                                        wreq_we_i,
    input  logic [WIDE_DW-1:0]                          wreq_wdata_i,
    input  logic [WIDE_BE-1:0]                          wreq_be_i,
    output logic                                        gwreq_gnt_o,
    // Bank side
    output logic [BANKS_PER_GROUP-1:0]                  bank_en_o,
    output logic [BANKS_PER_GROUP-1:0]                  bank_we_o,
    output logic [BANKS_PER_GROUP-1:0][IN_BANK_AW-1:0]  bank_addr_o,
    output logic [BANKS_PER_GROUP-1:0][NARROW_DW-1:0]   bank_wdata_o,
    output logic [BANKS_PER_GROUP-1:0][NARROW_BE-1:0]   bank_be_o,
    input  logic [BANKS_PER_GROUP-1:0][NARROW_DW-1:0]   bank_rdata_i,
    output logic [WIDE_DW-1:0]                          wrdata_o
);

    logic starve_q;
    logic wide_own_q;
    logic narrow_any;

    // ----------------------------------------
    // Wide vs narrow priority
    // ----------------------------------------
    assign narrow_any = |bnreq_valid_i;

    // Wide wins unless narrow traffic was already pushed back once
    assign gwreq_gnt_o = gwreq_valid_i && !(starve_q && narrow_any);
    assign bnreq_gnt_o = gwreq_gnt_o ? '0 : bnreq_valid_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            starve_q   <= 1'b0;
            wide_own_q <= 1'b0;
        end else begin
            if (|bnreq_gnt_o) begin
                starve_q <= 1'b0;
            end else if (narrow_any && gwreq_gnt_o) begin
                starve_q <= 1'b1;
            end
            wide_own_q <= gwreq_gnt_o;
        end
    end

    // ----------------------------------------
    // Wide slicing and bank mux
    // ----------------------------------------
    always_comb begin
        for (int b = 0; b < BANKS_PER_GROUP; b++) begin
            bank_en_o[b] = gwreq_gnt_o || bnreq_gnt_o[b];
            if (gwreq_gnt_o) begin
                bank_we_o[b]    = wreq_we_i;
                bank_addr_o[b]  = wreq_addr_i;
                bank_wdata_o[b] = wreq_wdata_i[b*NARROW_DW +: NARROW_DW];
                bank_be_o[b]    = wreq_be_i[b*NARROW_BE +: NARROW_BE];
            end else begin
                bank_we_o[b]    = bnreq_we_i[b];
                bank_addr_o[b]  = bnreq_addr_i[b];
                bank_wdata_o[b] = bnreq_wdata_i[b];
                bank_be_o[b]    = bnreq_be_i[b];
            end
        end
    end

    // Part 0 lands in the low word
    assign wrdata_o = wide_own_q ? bank_rdata_i : '0;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(gwreq_gnt_o && |bnreq_gnt_o));

    // A bank access needs a grant backed by a live request
    for (genvar b = 0; b < BANKS_PER_GROUP; b++) begin : g_en_chk
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            bank_en_o[b] |-> ((gwreq_gnt_o && gwreq_valid_i)
                || (bnreq_gnt_o[b] && bnreq_valid_i[b])));
    end

endmodule

/* source/island_xbar.sv */
`timescale 1ns/1ps

module island_xbar import mem_island_pkg::*; (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    // Narrow ports
    input  logic [NUM_NARROW_PORTS-1:0]                  nreq_valid_i,
    output logic [NUM_NARROW_PORTS-1:0]                  nreq_ready_o,
    input  logic [NUM_NARROW_PORTS-1:0][ADDR_W-1:0]      nreq_addr_i,
    input  logic [NUM_NARROW_PORTS-1:0]                  nreq_we_i,
    input  logic [NUM_NARROW_PORTS-1:0][NARROW_DW-1:0]   nreq_wdata_i,
    input  logic [NUM_NARROW_PORTS-1:0][NARROW_BE-1:0]   nreq_be_i,
    output logic [NUM_NARROW_PORTS-1:0]                  nrsp_valid_o,
    output logic [NUM_NARROW_PORTS-1:0][NARROW_DW-1:0]   nrsp_rdata_o,
    // Wide port
    input  logic                                         wreq_valid_i,
    output logic                                         wreq_ready_o,
    input  logic [ADDR_W-1:0]                            wreq_addr_i,
    input  logic                                         wreq_we_i,
    input  logic [WIDE_DW-1:0]                           wreq_wdata_i,
    input  logic [WIDE_BE-1:0]                           wreq_be_i,
    output logic                                         wrsp_valid_o,
    output logic [WIDE_DW-1:0]                           wrsp_rdata_o,
    // Narrow requests towards the banks
    output logic [NUM_BANKS-1:0]                         bnreq_valid_o,
    output logic [NUM_BANKS-1:0][IN_BANK_AW-1:0]         bnreq_addr_o,
    output logic [NUM_BANKS-1:0]                         bnreq_we_o,
    output logic [NUM_BANKS-1:0][NARROW_DW-1:0]          bnreq_wdata_o,
    output logic [NUM_BANKS-1:0][NARROW_BE-1:0]          bnreq_be_o,
    input  logic [NUM_BANKS-1:0]                         bnreq_gnt_i,
    // Wide request towards the groups
    output logic [NUM_GROUPS-1:0]                        gwreq_valid_o,
    output logic [IN_BANK_AW-1:0]                        gwreq_addr_o,
    output logic                                         gwreq_we_o,
    output logic [WIDE_DW-1:0]                           gwreq_wdata_o,
    output logic [WIDE_BE-1:0]                           gwreq_be_o,
    input  logic [NUM_GROUPS-1:0]                        gwreq_gnt_i,
    // Read data
    input  logic [NUM_BANKS-1:0][NARROW_DW-1:0]          bank_rdata_i,
    input  logic [NUM_GROUPS-1:0][WIDE_DW-1:0]           group_wrdata_i
);

    mem_addr_u [NUM_NARROW_PORTS-1:0]        naddr;
    mem_addr_u                               waddr;
    logic [NUM_BANKS-1:0][PORT_SEL_W-1:0]    rr_q;
    logic [NUM_BANKS-1:0][PORT_SEL_W-1:0]    win;
    logic [NUM_NARROW_PORTS-1:0]             nrsp_pend_q;
    logic [NUM_NARROW_PORTS-1:0][BANK_SEL_W-1:0] nrsp_bank_q;
    logic                                    wrsp_pend_q;
    logic [GROUP_SEL_W-1:0]                  wrsp_group_q;

    assign naddr = nreq_addr_i;
    assign waddr = wreq_addr_i;

    // ----------------------------------------
    // Narrow routing, round-robin per bank
    // ----------------------------------------
    always_comb begin
        int unsigned idx;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bnreq_valid_o[b] = 1'b0;
            win[b] = rr_q[b];
            // Scan downwards so the port nearest the pointer wins
            for (int k = NUM_NARROW_PORTS - 1; k >= 0; k--) begin
                idx = (int'(rr_q[b]) + k) % NUM_NARROW_PORTS;
                if (nreq_valid_i[idx] && naddr[idx].narrow.bank == BANK_SEL_W'(b)) begin
                    bnreq_valid_o[b] = 1'b1;
                    win[b] = PORT_SEL_W'(idx);
                end
            end
            bnreq_addr_o[b]  = naddr[win[b]].narrow.in_bank;
            bnreq_we_o[b]    = nreq_we_i[win[b]];
            bnreq_wdata_o[b] = nreq_wdata_i[win[b]];
            bnreq_be_o[b]    = nreq_be_i[win[b]];
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
            nreq_ready_o[p] = nreq_valid_i[p]
                && bnreq_gnt_i[naddr[p].narrow.bank]
                && win[naddr[p].narrow.bank] == PORT_SEL_W'(p);
        end
    end

    // ----------------------------------------
    // Wide routing to one bank group
    // ----------------------------------------
    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            gwreq_valid_o[g] = wreq_valid_i && waddr.wide.group == GROUP_SEL_W'(g);
        end
    end

    assign wreq_ready_o  = gwreq_gnt_i[waddr.wide.group];
    assign gwreq_addr_o  = waddr.wide.in_bank;
    assign gwreq_we_o    = wreq_we_i;
    assign gwreq_wdata_o = wreq_wdata_i;
    assign gwreq_be_o    = wreq_be_i;

    // ----------------------------------------
    // Pointers and response owners
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q         <= '0;
            nrsp_pend_q  <= '0;
            nrsp_bank_q  <= '0;
            wrsp_pend_q  <= 1'b0;
            wrsp_group_q <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bnreq_valid_o[b] && bnreq_gnt_i[b]) begin
                    rr_q[b] <= PORT_SEL_W'((int'(win[b]) + 1) % NUM_NARROW_PORTS);
                end
            end
            for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
                nrsp_pend_q[p] <= nreq_valid_i[p] && nreq_ready_o[p];
                nrsp_bank_q[p] <= naddr[p].narrow.bank;
            end
            wrsp_pend_q  <= wreq_valid_i && wreq_ready_o;
            wrsp_group_q <= waddr.wide.group;
        end
    end

    // Data comes from the bank register one cycle after acceptance
    always_comb begin
        for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
            nrsp_rdata_o[p] = bank_rdata_i[nrsp_bank_q[p]];
        end
    end

    assign nrsp_valid_o = nrsp_pend_q;
    assign wrsp_valid_o = wrsp_pend_q;
    assign wrsp_rdata_o = group_wrdata_i[wrsp_group_q];

    // One narrow winner per bank
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_acc_chk
        logic [NUM_NARROW_PORTS-1:0] acc;
        always_comb begin
            for (int p = 0; p < NUM_NARROW_PORTS; p++) begin
                acc[p] = nreq_valid_i[p] && nreq_ready_o[p]
                    && naddr[p].narrow.bank == BANK_SEL_W'(b);
            end
        end
        assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(acc));
    end

endmodule

/* source/mem_bank.sv */
`timescale 1ns/1ps

module mem_bank import mem_island_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  en_i,
    input  logic                  we_i,
    input  logic [IN_BANK_AW-1:0] addr_i,
    input  logic [NARROW_DW-1:0]  wdata_i,
    input  logic [NARROW_BE-1:0]  be_i,
    output logic [NARROW_DW-1:0]  rdata_o
);

    logic [NARROW_DW-1:0] mem_q [WORDS_PER_BANK];
    logic [NARROW_DW-1:0] rdata_q;

    // Byte-enabled write
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int i = 0; i < NARROW_BE; i++) begin
                if (be_i[i]) begin
                    mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // Registered read, a write answers with zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (en_i) begin
            rdata_q <= we_i ? '0 : mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* source/mem_island_pkg.sv */
package mem_island_pkg;

    // ----------------------------------------
    // Data path geometry
    // ----------------------------------------
    localparam int unsigned NARROW_DW = 32;
    localparam int unsigned NARROW_BE = NARROW_DW / 8;
    localparam int unsigned WIDE_DW   = 128;
    localparam int unsigned WIDE_BE   = WIDE_DW / 8;

    // Banking, four narrow banks make one wide word
    localparam int unsigned NUM_BANKS       = 8;
    localparam int unsigned BANKS_PER_GROUP = WIDE_DW / NARROW_DW;
    localparam int unsigned NUM_GROUPS      = NUM_BANKS / BANKS_PER_GROUP;
    localparam int unsigned WORDS_PER_BANK  = 64;
    localparam int unsigned IN_BANK_AW      = $clog2(WORDS_PER_BANK);

    // Requestors
    localparam int unsigned NUM_NARROW_PORTS = 2;
    localparam int unsigned PORT_SEL_W       = $clog2(NUM_NARROW_PORTS);

    // ----------------------------------------
    // Address fields
    // ----------------------------------------
    localparam int unsigned OFFSET_W    = $clog2(NARROW_BE);
    localparam int unsigned BANK_SEL_W  = $clog2(NUM_BANKS);
    localparam int unsigned PART_SEL_W  = $clog2(BANKS_PER_GROUP);
    localparam int unsigned GROUP_SEL_W = $clog2(NUM_GROUPS);
    localparam int unsigned ADDR_W      = IN_BANK_AW + BANK_SEL_W + OFFSET_W;

    // Byte address seen by either port
    // The narrow bank index is the group followed by the part
    typedef union packed {
        struct packed {
            logic [IN_BANK_AW-1:0] in_bank;
            logic [BANK_SEL_W-1:0] bank;
            logic [OFFSET_W-1:0]   offset;
        } narrow;
        struct packed {
            logic [IN_BANK_AW-1:0]  in_bank;
            logic [GROUP_SEL_W-1:0] group;
            logic [PART_SEL_W-1:0]  part;
            logic [OFFSET_W-1:0]    offset;
        } wide;
    } mem_addr_u;

endpackage

/* source/mem_island_top.sv */
`timescale 1ns/1ps

module mem_island_top import mem_island_pkg::*; (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  logic [NUM_NARROW_PORTS-1:0]                  nreq_valid_i,
    output logic [NUM_NARROW_PORTS-1:0]                  nreq_ready_o,
    input  logic [NUM_NARROW_PORTS-1:0][ADDR_W-1:0]      nreq_addr_i,
    input  logic [NUM_NARROW_PORTS-1:0]                  nreq_we_i,
    input  logic [NUM_NARROW_PORTS-1:0][NARROW_DW-1:0]   nreq_wdata_i,
    input  logic [NUM_NARROW_PORTS-1:0][NARROW_BE-1:0]   nreq_be_i,
    output logic [NUM_NARROW_PORTS-1:0]                  nrsp_valid_o,
    output logic [NUM_NARROW_PORTS-1:0][NARROW_DW-1:0]   nrsp_rdata_o,
    input  logic                                         wreq_valid_i,
    output logic                                         wreq_ready_o,
    input  logic [ADDR_W-1:0]                            wreq_addr_i,
    input  logic                                         wreq_we_i,
    input  logic [WIDE_DW-1:0]                           wreq_wdata_i,
    input  logic [WIDE_BE-1:0]                           wreq_be_i,
    output logic                                         wrsp_valid_o,
    output logic [WIDE_DW-1:0]                           wrsp_rdata_o
);

    // Crossbar to group arbiters
    logic [NUM_BANKS-1:0]                 bnreq_valid;
    logic [NUM_BANKS-1:0][IN_BANK_AW-1:0] bnreq_addr;
    logic [NUM_BANKS-1:0]                 bnreq_we;
    logic [NUM_BANKS-1:0][NARROW_DW-1:0]  bnreq_wdata;
    logic [NUM_BANKS-1:0][NARROW_BE-1:0]  bnreq_be;
    logic [NUM_BANKS-1:0]                 bnreq_gnt;
    logic [NUM_GROUPS-1:0]                gwreq_valid;
    logic [IN_BANK_AW-1:0]                gwreq_addr;
    logic                                 gwreq_we;
    logic [WIDE_DW-1:0]                   gwreq_wdata;
    logic [WIDE_BE-1:0]                   gwreq_be;
    logic [NUM_GROUPS-1:0]                gwreq_gnt;
    logic [NUM_GROUPS-1:0][WIDE_DW-1:0]   group_wrdata;

    // Arbiters to banks
    logic [NUM_BANKS-1:0]                 bank_en;
    logic [NUM_BANKS-1:0]                 bank_we;
    logic [NUM_BANKS-1:0][IN_BANK_AW-1:0] bank_addr;
    logic [NUM_BANKS-1:0][NARROW_DW-1:0]  bank_wdata;
    logic [NUM_BANKS-1:0][NARROW_BE-1:0]  bank_be;
    logic [NUM_BANKS-1:0][NARROW_DW-1:0]  bank_rdata;

    island_xbar u_xbar (
        .clk_i, .arst_n_i,
        .nreq_valid_i, .nreq_ready_o, .nreq_addr_i, .nreq_we_i, .nreq_wdata_i, .nreq_be_i,
        .nrsp_valid_o, .nrsp_rdata_o,
        .wreq_valid_i, .wreq_ready_o, .wreq_addr_i, .wreq_we_i, .wreq_wdata_i, .wreq_be_i,
        .wrsp_valid_o, .wrsp_rdata_o,
        .bnreq_valid_o (bnreq_valid),
        .bnreq_addr_o  (bnreq_addr),
        .bnreq_we_o    (bnreq_we),
        .bnreq_wdata_o (bnreq_wdata),
        .bnreq_be_o    (bnreq_be),
        .bnreq_gnt_i   (bnreq_gnt),
        .gwreq_valid_o (gwreq_valid),
        .gwreq_addr_o  (gwreq_addr),
        .gwreq_we_o    (gwreq_we),
        .gwreq_wdata_o (gwreq_wdata),
        .gwreq_be_o    (gwreq_be),
        .gwreq_gnt_i   (gwreq_gnt),
        .bank_rdata_i  (bank_rdata),
        .group_wrdata_i(group_wrdata)
    );

    // ----------------------------------------
    // Group arbiters
    // ----------------------------------------
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
        bank_group_arbiter u_group_arb (
            .clk_i, .arst_n_i,
            .bnreq_valid_i(bnreq_valid[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bnreq_addr_i (bnreq_addr[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bnreq_we_i   (bnreq_we[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bnreq_wdata_i(bnreq_wdata[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bnreq_be_i   (bnreq_be[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bnreq_gnt_o  (bnreq_gnt[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .gwreq_valid_i(gwreq_valid[g]),
            .wreq_addr_i  (gwreq_addr),
            .wreq_we_i    (gwreq_we),
            .wreq_wdata_i (gwreq_wdata),
            .wreq_be_i    (gwreq_be),
            .gwreq_gnt_o  (gwreq_gnt[g]),
            .bank_en_o    (bank_en[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bank_we_o    (bank_we[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bank_addr_o  (bank_addr[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bank_wdata_o (bank_wdata[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bank_be_o    (bank_be[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bank_rdata_i (bank_rdata[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .wrdata_o     (group_wrdata[g])
        );
    end

    // ----------------------------------------
    // Banks
    // ----------------------------------------
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_bank u_bank (
            .clk_i, .arst_n_i,
            .en_i   (bank_en[b]),
            .we_i   (bank_we[b]),
            .addr_i (bank_addr[b]),
            .wdata_i(bank_wdata[b]),
            .be_i   (bank_be[b]),
            .rdata_o(bank_rdata[b])
        );
    end

endmodule

/* vlog.f */
source/mem_island_pkg.sv
source/mem_bank.sv
source/island_xbar.sv
source/bank_group_arbiter.sv
source/mem_island_top.sv
dv/tb_mem_island.sv
